// File: camera_pkg.sv
`default_nettype none

package camera_pkg;

    localparam int FRAME_PIXELS_DEFAULT = 64; // Power of two, 8 or more
    localparam int ADDRESS_WIDTH = 16;

    // Register opcodes, first byte of every SPI transaction
    typedef enum logic [7:0] {
        op_start_capture     = 8'h20,
        op_bytes_remaining   = 8'h21,
        op_image_data        = 8'h22,
        op_zoom              = 8'h23,
        op_pan               = 8'h24,
        op_metering_data     = 8'h25,
        op_quality_factor    = 8'h26,
        op_image_ready_flag  = 8'h27,
        op_power_save_enable = 8'h28
    } opcode_t;

    typedef struct packed {
        logic       valid;
        logic       frame_start; // First pixel of a frame
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } pixel_t;

    // Byte order here is the metering readout order
    typedef struct packed {
        logic [7:0] red_center;
        logic [7:0] green_center;
        logic [7:0] blue_center;
        logic [7:0] red_average;
        logic [7:0] green_average;
        logic [7:0] blue_average;
    } metering_t;

    typedef struct packed {
        logic spi_clock;
        logic spi_select_n;
        logic spi_copi;
    } spi_bus_t;

    typedef enum logic [1:0] {
        st_idle,
        st_wait_frame,
        st_capturing,
        st_done
    } capture_state_t;

endpackage

`default_nettype wire

// File: spi_peripheral.sv
`default_nettype none

module spi_peripheral (
    input logic clock_in,
    input logic reset_n_in,
    input camera_pkg::spi_bus_t spi_bus,
    output logic spi_cipo,
    input logic [7:0] response,
    output camera_pkg::opcode_t opcode,
    output logic [7:0] operand,
    output logic operand_valid,
    output logic operand_read,
    output logic [31:0] rd_operand_count
);
    import camera_pkg::*;

    localparam spi_bus_t BUS_IDLE = '{spi_clock: 1'b0, spi_select_n: 1'b1, spi_copi: 1'b0};

    spi_bus_t bus_meta;
    spi_bus_t bus_sync;
    logic clock_prev;
    logic clock_rise;
    logic clock_fall;
    logic [2:0] bit_count;
    logic opcode_done;      // First byte of the transaction is in
    logic [7:0] rx_shift;
    logic [7:0] rx_byte;
    logic [7:0] tx_shift;

    // Two flop synchroniser plus one stage for edge detect
    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            bus_meta <= BUS_IDLE;
            bus_sync <= BUS_IDLE;
            clock_prev <= 1'b0;
        end else begin
            bus_meta <= spi_bus;
            bus_sync <= bus_meta;
            clock_prev <= bus_sync.spi_clock;
        end
    end

    assign clock_rise = bus_sync.spi_clock & ~clock_prev;
    assign clock_fall = ~bus_sync.spi_clock & clock_prev;
    assign rx_byte = {rx_shift[6:0], bus_sync.spi_copi}; // Byte including current bit

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            bit_count <= 3'd0;
            opcode_done <= 1'b0;
            opcode <= opcode_t'(8'h00);
            rd_operand_count <= 32'd0;
            operand_valid <= 1'b0;
            operand_read <= 1'b0;
        end else begin
            operand_valid <= 1'b0;
            operand_read <= 1'b0;
            if (bus_sync.spi_select_n) begin
                bit_count <= 3'd0;
                opcode_done <= 1'b0;
                rd_operand_count <= 32'd0;
            end else if (clock_rise) begin
                bit_count <= bit_count + 3'd1;
                if (bit_count == 3'd7) begin
                    if (!opcode_done) begin
                        opcode <= opcode_t'(rx_byte);
                        opcode_done <= 1'b1;
                    end else begin
                        operand_valid <= 1'b1;
                        operand_read <= 1'b1; // Response byte fully shifted out
                        rd_operand_count <= rd_operand_count + 32'd1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clock_in) begin
        if (clock_rise && !bus_sync.spi_select_n) begin
            rx_shift <= rx_byte;
            if (bit_count == 3'd7 && opcode_done) begin
                operand <= rx_byte;
            end
        end
    end

    // Mode 0, so the next bit goes out on the falling edge
    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            tx_shift <= 8'd0;
        end else if (bus_sync.spi_select_n) begin
            tx_shift <= 8'd0;
        end else if (clock_fall) begin
            if (bit_count == 3'd0) begin
                tx_shift <= response; // Byte boundary
            end else begin
                tx_shift <= {tx_shift[6:0], 1'b0};
            end
        end
    end

    assign spi_cipo = tx_shift[7];

    opcode_stable: assert property (@(posedge clock_in) disable iff (!reset_n_in)
        (opcode_done && !bus_sync.spi_select_n) |=> $stable(opcode))
        else $error("Opcode changed during a transaction");

endmodule

`default_nettype wire

// File: spi_registers.sv
`default_nettype none

module spi_registers (
    input logic clock_in,
    input logic reset_n_in,

    // From the SPI peripheral
    input camera_pkg::opcode_t opcode,
    input logic [7:0] operand,
    input logic operand_valid,
    input logic operand_read,
    input logic [31:0] rd_operand_count,
    output logic [7:0] response,

    // Control
    output logic start_capture,
    output logic [1:0] compression_factor,
    output logic power_save_enable,

    // Image and metering
    input logic image_ready,
    input logic [camera_pkg::ADDRESS_WIDTH-1:0] image_total_size,
    input logic [7:0] image_data,
    output logic [camera_pkg::ADDRESS_WIDTH-1:0] image_address,
    input camera_pkg::metering_t metering
);
    import camera_pkg::*;

    logic [ADDRESS_WIDTH-1:0] bytes_remaining;

    assign bytes_remaining = image_total_size - image_address;

    always_comb begin
        case (opcode)
            op_bytes_remaining: begin
                if (rd_operand_count == 32'd0) begin
                    response = bytes_remaining[15:8]; // High byte first
                end else begin
                    response = bytes_remaining[7:0];
                end
            end
            op_image_data: response = image_data;
            op_metering_data: begin
                case (rd_operand_count)
                    32'd0: response = metering.red_center;
                    32'd1: response = metering.green_center;
                    32'd2: response = metering.blue_center;
                    32'd3: response = metering.red_average;
                    32'd4: response = metering.green_average;
                    default: response = metering.blue_average; // Repeats past the end
                endcase
            end
            op_image_ready_flag: response = {7'd0, image_ready};
            default: response = 8'd0;
        endcase
    end

    assign start_capture = operand_valid && (opcode == op_start_capture);

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            compression_factor <= 2'd0;
            power_save_enable <= 1'b1;
            image_address <= '0;
        end else begin
            // Auto increment while reading image bytes
            if (operand_read && opcode == op_image_data) begin
                if (image_address < image_total_size) begin
                    image_address <= image_address + 1'b1;
                end
            end

            if (operand_valid) begin
                case (opcode)
                    op_start_capture: image_address <= '0;
                    op_quality_factor: compression_factor <= operand[1:0];
                    op_power_save_enable: power_save_enable <= operand[0];
                    op_zoom, op_pan: ; // Accepted, no effect yet
                    default: ;
                endcase
            end
        end
    end

    // Address is bounded by what the buffer holds
    address_in_range: assert property (@(posedge clock_in) disable iff (!reset_n_in)
        image_address <= image_total_size)
        else $error("Image address beyond image size");

endmodule

`default_nettype wire

// File: capture_fsm.sv
`default_nettype none

module capture_fsm (
    input logic clock_in,
    input logic reset_n_in,
    input logic start_capture,
    input logic power_save_enable,
    input camera_pkg::pixel_t pixel,
    input logic last_pixel,
    output logic count_enable,
    output logic count_clear,
    output logic capture_active,
    output logic image_ready
);
    import camera_pkg::*;

    capture_state_t state;
    logic start_accepted;
    logic frame_begin;

    assign start_accepted = start_capture & ~power_save_enable; // Ignored in power save
    assign frame_begin = pixel.valid & pixel.frame_start;

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            state <= st_idle;
        end else if (start_accepted) begin
            state <= st_wait_frame; // Also re-arms a running or finished capture
        end else begin
            case (state)
                st_wait_frame: begin
                    if (frame_begin) begin
                        state <= st_capturing;
                    end
                end
                st_capturing: begin
                    if (last_pixel) begin
                        state <= st_done;
                    end
                end
                default: state <= state; // Idle and done hold
            endcase
        end
    end

    // Frame start pixel is taken while still waiting
    assign capture_active = (state == st_capturing) ||
                            (state == st_wait_frame && frame_begin);
    assign count_enable = capture_active & pixel.valid;
    assign count_clear = start_accepted;
    assign image_ready = (state == st_done);

    ready_excludes_active: assert property (@(posedge clock_in) disable iff (!reset_n_in)
        !(image_ready && capture_active))
        else $error("Image ready while capture active");

endmodule

`default_nettype wire

// File: pixel_counter.sv
`default_nettype none

module pixel_counter #(
    parameter int FRAME_PIXELS = camera_pkg::FRAME_PIXELS_DEFAULT
) (
    input logic clock_in,
    input logic reset_n_in,
    input logic count_clear,
    input logic count_enable,
    output logic [camera_pkg::ADDRESS_WIDTH-1:0] pixel_index,
    output logic last_pixel
);
    import camera_pkg::*;

    localparam logic [ADDRESS_WIDTH-1:0] LAST_INDEX = ADDRESS_WIDTH'(FRAME_PIXELS - 1);

    logic [ADDRESS_WIDTH-1:0] count;

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            count <= '0;
        end else if (count_clear) begin
            count <= '0; // New capture armed
        end else if (count_enable) begin
            count <= count + 1'b1;
        end
    end

    assign pixel_index = count;
    assign last_pixel = count_enable && (count == LAST_INDEX); // Enable implies valid

endmodule

`default_nettype wire

// File: image_buffer.sv
`default_nettype none

module image_buffer #(
    parameter int FRAME_PIXELS = camera_pkg::FRAME_PIXELS_DEFAULT
) (
    input logic clock_in,
    input logic reset_n_in,
    input camera_pkg::pixel_t pixel,
    input logic capture_active,
    input logic count_clear,
    input logic [camera_pkg::ADDRESS_WIDTH-1:0] pixel_index,
    input logic [1:0] compression_factor,
    input logic [camera_pkg::ADDRESS_WIDTH-1:0] image_address,
    output logic [camera_pkg::ADDRESS_WIDTH-1:0] image_total_size,
    output logic [7:0] image_data
);
    import camera_pkg::*;

    localparam int INDEX_WIDTH = $clog2(FRAME_PIXELS);

    logic [7:0] memory [FRAME_PIXELS];
    logic [ADDRESS_WIDTH-1:0] write_pointer;
    logic [ADDRESS_WIDTH-1:0] sample_mask;
    logic [9:0] luma_sum;
    logic keep_pixel;

    // Luma approximation (r + 2g + b) / 4
    assign luma_sum = {2'b00, pixel.red} + {1'b0, pixel.green, 1'b0} + {2'b00, pixel.blue};

    // Keep every 2^f-th pixel
    assign sample_mask = (ADDRESS_WIDTH'(1) << compression_factor) - 1'b1;
    assign keep_pixel = capture_active && pixel.valid && ((pixel_index & sample_mask) == '0);

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            write_pointer <= '0;
        end else if (count_clear) begin
            write_pointer <= '0;
        end else if (keep_pixel) begin
            write_pointer <= write_pointer + 1'b1;
        end
    end

    always_ff @(posedge clock_in) begin
        if (keep_pixel && !count_clear) begin
            memory[write_pointer[INDEX_WIDTH-1:0]] <= luma_sum[9:2];
        end
        // Reads past the written data give zero
        image_data <= (image_address < write_pointer) ? memory[image_address[INDEX_WIDTH-1:0]]
                                                      : 8'd0;
    end

    assign image_total_size = write_pointer;

endmodule

`default_nettype wire

// File: metering.sv
`default_nettype none

module metering #(
    parameter int FRAME_PIXELS = camera_pkg::FRAME_PIXELS_DEFAULT
) (
    input logic clock_in,
    input logic reset_n_in,
    input camera_pkg::pixel_t pixel,
    input logic capture_active,
    input logic count_clear,
    input logic [camera_pkg::ADDRESS_WIDTH-1:0] pixel_index,
    output camera_pkg::metering_t metering
);
    import camera_pkg::*;

    localparam int INDEX_WIDTH = $clog2(FRAME_PIXELS);
    localparam int SUM_WIDTH = 8 + INDEX_WIDTH;
    localparam logic [ADDRESS_WIDTH-1:0] CENTRE_FIRST = ADDRESS_WIDTH'(3 * FRAME_PIXELS / 8);
    localparam logic [ADDRESS_WIDTH-1:0] CENTRE_END = ADDRESS_WIDTH'(5 * FRAME_PIXELS / 8);
    localparam logic [ADDRESS_WIDTH-1:0] LAST_INDEX = ADDRESS_WIDTH'(FRAME_PIXELS - 1);

    logic [7:0] channel [3];        // Red, green, blue
    logic [SUM_WIDTH-1:0] total_sum [3];
    logic [SUM_WIDTH-1:0] total_next [3];
    logic [SUM_WIDTH-1:0] centre_sum [3];
    logic [SUM_WIDTH-1:0] centre_next [3];
    logic [SUM_WIDTH-1:0] total_mean [3];
    logic [SUM_WIDTH-1:0] centre_mean [3];
    logic accept;
    logic in_centre;
    logic final_pixel;

    assign accept = capture_active & pixel.valid;
    assign in_centre = (pixel_index >= CENTRE_FIRST) && (pixel_index < CENTRE_END);
    assign final_pixel = accept && (pixel_index == LAST_INDEX);

    always_comb begin
        channel[0] = pixel.red;
        channel[1] = pixel.green;
        channel[2] = pixel.blue;
        for (int i = 0; i < 3; i++) begin
            total_next[i] = total_sum[i] + (accept ? SUM_WIDTH'(channel[i]) : '0);
            centre_next[i] = centre_sum[i] + ((accept && in_centre) ? SUM_WIDTH'(channel[i]) : '0);
            total_mean[i] = total_next[i] >> INDEX_WIDTH;
            centre_mean[i] = centre_next[i] >> (INDEX_WIDTH - 2); // Centre is N/4 pixels
        end
    end

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            for (int i = 0; i < 3; i++) begin
                total_sum[i] <= '0;
                centre_sum[i] <= '0;
            end
            metering <= '0;
        end else if (count_clear) begin
            for (int i = 0; i < 3; i++) begin
                total_sum[i] <= '0;
                centre_sum[i] <= '0;
            end
        end else begin
            total_sum <= total_next;
            centre_sum <= centre_next;
            if (final_pixel) begin
                metering.red_center <= centre_mean[0][7:0];
                metering.green_center <= centre_mean[1][7:0];
                metering.blue_center <= centre_mean[2][7:0];
                metering.red_average <= total_mean[0][7:0];
                metering.green_average <= total_mean[1][7:0];
                metering.blue_average <= total_mean[2][7:0];
            end
        end
    end

endmodule

`default_nettype wire

// File: camera_top.sv
`default_nettype none

module camera_top #(
    parameter int FRAME_PIXELS = camera_pkg::FRAME_PIXELS_DEFAULT
) (
    input logic clock_in,
    input logic reset_n_in,
    input camera_pkg::spi_bus_t spi_bus,
    output logic spi_cipo,
    input camera_pkg::pixel_t pixel
);
    import camera_pkg::*;

    opcode_t opcode;
    logic [7:0] operand;
    logic operand_valid;
    logic operand_read;
    logic [31:0] rd_operand_count;
    logic [7:0] response;
    logic start_capture;
    logic [1:0] compression_factor;
    logic power_save_enable;
    logic image_ready;
    logic [ADDRESS_WIDTH-1:0] image_total_size;
    logic [ADDRESS_WIDTH-1:0] image_address;
    logic [7:0] image_data;
    metering_t metering_bytes;
    logic count_enable;
    logic count_clear;
    logic capture_active;
    logic last_pixel;
    logic [ADDRESS_WIDTH-1:0] pixel_index;

    spi_peripheral spi_peripheral_i (
        .clock_in, .reset_n_in, .spi_bus, .spi_cipo, .response,
        .opcode, .operand, .operand_valid, .operand_read, .rd_operand_count
    );

    spi_registers spi_registers_i (
        .clock_in, .reset_n_in, .opcode, .operand, .operand_valid, .operand_read,
        .rd_operand_count, .response, .start_capture, .compression_factor,
        .power_save_enable, .image_ready, .image_total_size, .image_data,
        .image_address, .metering(metering_bytes)
    );

    capture_fsm capture_fsm_i (
        .clock_in, .reset_n_in, .start_capture, .power_save_enable, .pixel,
        .last_pixel, .count_enable, .count_clear, .capture_active, .image_ready
    );

    pixel_counter #(.FRAME_PIXELS(FRAME_PIXELS)) pixel_counter_i (
        .clock_in, .reset_n_in, .count_clear, .count_enable, .pixel_index, .last_pixel
    );

    image_buffer #(.FRAME_PIXELS(FRAME_PIXELS)) image_buffer_i (
        .clock_in, .reset_n_in, .pixel, .capture_active, .count_clear, .pixel_index,
        .compression_factor, .image_address, .image_total_size, .image_data
    );

    metering #(.FRAME_PIXELS(FRAME_PIXELS)) metering_i (
        .clock_in, .reset_n_in, .pixel, .capture_active, .count_clear, .pixel_index,
        .metering(metering_bytes)
    );

endmodule

`default_nettype wire

// File: camera_tb.sv
`default_nettype none

module camera_tb;
    import camera_pkg::*;

    localparam int FRAME_PIXELS = 64;
    localparam int HALF_PERIOD = 5;                     // SPI half period in clocks
    localparam int SPI_BYTE_CYCLES = 16 * HALF_PERIOD;
    localparam int TIMEOUT_CYCLES = 2 * (5 * FRAME_PIXELS + 300 * SPI_BYTE_CYCLES);
    localparam int CENTRE_FIRST = 3 * FRAME_PIXELS / 8;
    localparam int CENTRE_END = 5 * FRAME_PIXELS / 8;

    logic clock_in;
    logic reset_n_in;
    spi_bus_t spi_bus;
    logic spi_cipo;
    pixel_t pixel;

    int model_luma [FRAME_PIXELS];
    int model_centre [3];                               // Red, green, blue
    int model_average [3];
    int cycle_count = 0;
    int check_count = 0;
    int error_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int errors_before_test = 0;
    string test_name;

    camera_top #(.FRAME_PIXELS(FRAME_PIXELS)) camera_top_i (
        .clock_in, .reset_n_in, .spi_bus, .spi_cipo, .pixel
    );

    initial begin
        clock_in = 1'b0;
        forever #20 clock_in = ~clock_in;
    end

    // Watchdog
    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock_in);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
        $display("Test failures found");
        $finish;
    end

    task automatic wait_cycles(input int count);
        repeat (count) @(posedge clock_in);
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        check_count++;
        assert (actual == expected) else begin
            $display("** Error %s, %s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errors_before_test = error_count;
    endtask

    task automatic finish_test();
        tests_run++;
        if (error_count == errors_before_test) begin
            $display("Test %s: PASS", test_name);
        end else begin
            tests_failed++;
            $display("Test %s: FAIL", test_name);
        end
    endtask

    task automatic spi_begin();
        @(posedge clock_in);
        spi_bus.spi_clock <= 1'b0;
        spi_bus.spi_select_n <= 1'b0;
        wait_cycles(HALF_PERIOD - 1);
    endtask

    // Mode 0, data changes with the falling edge and is sampled on the rising one
    task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
        for (int i = 7; i >= 0; i--) begin
            @(posedge clock_in);
            spi_bus.spi_clock <= 1'b0;
            spi_bus.spi_copi <= tx[i];
            wait_cycles(HALF_PERIOD - 1);
            @(posedge clock_in);
            rx[i] = spi_cipo;                           // Settled since the falling edge
            spi_bus.spi_clock <= 1'b1;
            wait_cycles(HALF_PERIOD - 1);
        end
    endtask

    task automatic spi_end();
        @(posedge clock_in);
        spi_bus.spi_clock <= 1'b0;
        wait_cycles(HALF_PERIOD - 1);
        @(posedge clock_in);
        spi_bus.spi_select_n <= 1'b1;
        wait_cycles(2 * HALF_PERIOD);                   // Select seen high before the next one
    endtask

    task automatic write_register(input logic [7:0] op, input logic [7:0] value);
        logic [7:0] discard;
        spi_begin();
        spi_byte(op, discard);
        spi_byte(value, discard);
        spi_end();
    endtask

    task automatic read_register(input logic [7:0] op, output logic [7:0] value);
        logic [7:0] discard;
        spi_begin();
        spi_byte(op, discard);
        spi_byte(8'h00, value);
        spi_end();
    endtask

    task automatic read_bytes_remaining(output int count);
        logic [7:0] discard;
        logic [7:0] high;
        logic [7:0] low;
        spi_begin();
        spi_byte(op_bytes_remaining, discard);
        spi_byte(8'h00, high);                          // High byte first
        spi_byte(8'h00, low);
        spi_end();
        count = {high, low};
    endtask

    // Image byte n holds the luma of pixel n * step
    task automatic check_image(input int first, input int count, input int step);
        logic [7:0] discard;
        logic [7:0] data;
        spi_begin();
        spi_byte(op_image_data, discard);
        for (int i = 0; i < count; i++) begin
            spi_byte(8'h00, data);
            check_value($sformatf("image byte %0d", first + i),
                        model_luma[(first + i) * step], data);
        end
        spi_end();
    endtask

    task automatic check_metering();
        logic [7:0] discard;
        logic [7:0] data;
        spi_begin();
        spi_byte(op_metering_data, discard);
        for (int i = 0; i < 6; i++) begin
            spi_byte(8'h00, data);
            check_value($sformatf("metering byte %0d", i),
                        (i < 3) ? model_centre[i] : model_average[i - 3], data);
        end
        spi_end();
    endtask

    // Polls the ready flag over SPI
    task automatic wait_image_ready();
        logic [7:0] flag;
        int polls;
        polls = 0;
        flag = 8'd0;
        while (flag != 8'd1 && polls < 8) begin
            read_register(op_image_ready_flag, flag);
            polls++;
        end
        check_value("image ready flag", 1, flag);
    endtask

    task automatic send_frame();
        logic [7:0] colour [3];
        int centre_sum [3];
        int total_sum [3];
        for (int c = 0; c < 3; c++) begin
            centre_sum[c] = 0;
            total_sum[c] = 0;
        end
        for (int i = 0; i < 3; i++) begin
            @(posedge clock_in);
            pixel <= '{valid: 1'b1, frame_start: 1'b0, red: 8'hff, green: 8'hff, blue: 8'hff};
        end
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            for (int c = 0; c < 3; c++) begin
                colour[c] = 8'($urandom);
                total_sum[c] += colour[c];
                if (i >= CENTRE_FIRST && i < CENTRE_END) begin
                    centre_sum[c] += colour[c];
                end
            end
            @(posedge clock_in);
            pixel <= '{valid: 1'b1, frame_start: (i == 0),
                       red: colour[0], green: colour[1], blue: colour[2]};
            model_luma[i] = (int'(colour[0]) + 2 * int'(colour[1]) + int'(colour[2])) / 4;
        end
        @(posedge clock_in);
        pixel <= '0;
        for (int c = 0; c < 3; c++) begin
            model_centre[c] = centre_sum[c] / (FRAME_PIXELS / 4);   // Floor means
            model_average[c] = total_sum[c] / FRAME_PIXELS;
        end
    endtask

    initial begin
        logic [7:0] value;
        int remaining;
        void'($urandom(33842));
        spi_bus = '{spi_clock: 1'b0, spi_select_n: 1'b1, spi_copi: 1'b0};
        pixel = '0;
        reset_n_in = 1'b0;
        wait_cycles(10);
        reset_n_in <= 1'b1;
        wait_cycles(4);

        start_test("reset_and_power_save");
        read_register(op_image_ready_flag, value);
        check_value("image ready flag after reset", 0, value);
        write_register(op_start_capture, 8'h00);        // Power save still on
        send_frame();
        read_register(op_image_ready_flag, value);
        check_value("image ready flag in power save", 0, value);
        read_bytes_remaining(remaining);
        check_value("bytes remaining in power save", 0, remaining);
        finish_test();

        start_test("full_capture");
        write_register(op_power_save_enable, 8'h00);
        write_register(op_quality_factor, 8'h00);
        write_register(op_start_capture, 8'h00);
        send_frame();
        wait_image_ready();
        read_bytes_remaining(remaining);
        check_value("bytes remaining", FRAME_PIXELS, remaining);
        check_image(0, FRAME_PIXELS, 1);
        read_bytes_remaining(remaining);
        check_value("bytes remaining after reads", 0, remaining);
        read_register(op_image_data, value);
        check_value("image byte past the end", 0, value);
        finish_test();

        start_test("subsampling");
        write_register(op_quality_factor, 8'h02);
        write_register(op_start_capture, 8'h00);
        send_frame();
        wait_image_ready();
        read_bytes_remaining(remaining);
        check_value("bytes remaining", FRAME_PIXELS / 4, remaining);
        check_image(0, FRAME_PIXELS / 4, 4);
        finish_test();

        start_test("metering");
        check_metering();
        finish_test();

        start_test("restart");
        write_register(op_quality_factor, 8'h01);
        write_register(op_start_capture, 8'h00);
        send_frame();
        wait_image_ready();
        check_image(0, 4, 2);
        write_register(op_start_capture, 8'h00);        // Mid read
        read_register(op_image_ready_flag, value);
        check_value("image ready flag after restart", 0, value);
        send_frame();
        wait_image_ready();
        read_bytes_remaining(remaining);
        check_value("bytes remaining after restart", FRAME_PIXELS / 2, remaining);
        check_image(0, 2, 2);
        finish_test();

        start_test("ignored_opcodes");
        read_register(8'h30, value);
        check_value("unknown opcode", 0, value);
        write_register(op_zoom, 8'h5a);
        write_register(op_pan, 8'ha5);
        read_register(op_zoom, value);
        check_value("zoom readback", 0, value);
        read_register(op_image_ready_flag, value);
        check_value("image ready flag", 1, value);
        read_bytes_remaining(remaining);
        check_value("bytes remaining", FRAME_PIXELS / 2 - 2, remaining);
        check_metering();
        finish_test();

        $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
camera_pkg.sv
spi_peripheral.sv
spi_registers.sv
capture_fsm.sv
pixel_counter.sv
image_buffer.sv
metering.sv
camera_top.sv
camera_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the camera testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module camera_tb -f sources.f

status=0
./obj_dir/Vcamera_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Test failures found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation passed"
